// ==== hdl/cache_pkg.sv ====
package cache_pkg;

    // address split: tag | index | byte offset
    typedef logic [19:0]  tag_t;
    typedef logic [6:0]   index_t;
    typedef logic [4:0]   offset_t;
    typedef logic [2:0]   word_sel_t;
    typedef logic [31:0]  word_t;
    typedef logic [255:0] line_t;
    typedef logic [31:0]  line_strb_t;
    typedef logic [0:0]   way_t;
    typedef logic [31:0]  addr_t;

    // words per refill burst
    localparam int LINE_BEATS = 8;

    // transfer type for a whole line, read and write channel alike
    localparam logic [2:0] MEM_TYPE_LINE = 3'b100;

    localparam logic OP_READ  = 1'b0;
    localparam logic OP_WRITE = 1'b1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MISS,
        ST_REPLACE,
        ST_REFILL
    } cache_state_t;

endpackage

// ==== hdl/cache_req_if.sv ====
`timescale 1ns/1ps

// request as latched on the accepting edge
interface cache_req_if import cache_pkg::*; ();
    logic       op;
    tag_t       tag;
    index_t     index;
    word_sel_t  word_sel;
    word_t      wdata;
    line_strb_t line_wstrb;
    line_t      line_wdata;

    modport source (output op, tag, index, word_sel, wdata, line_wstrb, line_wdata);

    modport sink (input op, tag, index, word_sel, wdata, line_wstrb, line_wdata);

endinterface

// ==== hdl/cache_fill_if.sv ====
`timescale 1ns/1ps

// victim writeback and line refill between controller, arrays and memory port
interface cache_fill_if import cache_pkg::*; ();
    logic  idle;
    logic  replace;
    logic  refill;
    tag_t  victim_tag;
    line_t victim_line;
    logic  victim_dirty;
    line_t fill_line;
    logic  fill_done;

    modport ctrl (output idle, replace, refill, input victim_dirty, fill_done);

    modport arrays (input idle, refill, fill_line, fill_done,
                    output victim_tag, victim_line, victim_dirty);

    modport mem (input replace, refill, victim_tag, victim_line,
                 output fill_line, fill_done);

endinterface

// ==== hdl/cache_request_stage.sv ====
`timescale 1ns/1ps

module cache_request_stage import cache_pkg::*; (
    input  logic             clk,
    input  logic             resetn,
    input  logic             valid,
    input  logic             op,
    input  tag_t             tag,
    input  index_t           index,
    input  offset_t          offset,
    input  logic [3:0]       wstrb,
    input  word_t            wdata,
    input  logic             accept,
    cache_req_if.source      req
);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            req.op         <= OP_READ;
            req.line_wstrb <= '0;
        end else if (valid && accept) begin
            req.op <= op;
            // reads carry no strobe, so the refill merge leaves the line untouched
            req.line_wstrb <= (op == OP_WRITE) ?
                              (line_strb_t'(wstrb) << {offset[4:2], 2'b00}) : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (valid && accept) begin
            req.tag      <= tag;
            req.index    <= index;
            req.word_sel <= offset[4:2];
            req.wdata    <= wdata;
        end
    end

    // store word moved to its position in the line
    assign req.line_wdata = line_t'(req.wdata) << {req.word_sel, 5'b00000};

endmodule

// ==== hdl/cache_arrays.sv ====
`timescale 1ns/1ps

module cache_arrays import cache_pkg::*; (
    input  logic         clk,
    input  logic         resetn,
    input  logic         valid,
    input  index_t       index,
    cache_req_if.sink    req,
    cache_fill_if.arrays fill,
    input  logic         lookup_active,
    input  way_t         victim_way,
    output logic         hit,
    output word_t        rdata
);
    localparam int WAYS = 2 ** $bits(way_t);
    localparam int SETS = 2 ** $bits(index_t);

    tag_t  tag_mem  [WAYS][SETS];
    line_t data_mem [WAYS][SETS];
    logic [WAYS-1:0][SETS-1:0] valid_bits;
    logic [WAYS-1:0][SETS-1:0] dirty_bits;

    tag_t  preload_tag  [WAYS];
    line_t preload_line [WAYS];
    logic [WAYS-1:0] hit_way;
    way_t  hit_way_id;
    logic  preload_en;
    logic  line_we;
    way_t  write_way;
    line_t base_line;
    line_t merged_line;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_way[w] = valid_bits[w][req.index] && (preload_tag[w] == req.tag);
        end
    end

    assign hit        = lookup_active && (|hit_way);
    assign hit_way_id = way_t'(hit_way[1]);

    // next set is read only when the request will be taken
    assign preload_en = valid && (fill.idle || (hit && req.op == OP_READ));

    always_ff @(posedge clk) begin
        if (preload_en) begin
            for (int w = 0; w < WAYS; w++) begin
                preload_tag[w]  <= tag_mem[w][index];
                preload_line[w] <= data_mem[w][index];
            end
        end
    end

    assign base_line = fill.refill ? fill.fill_line : preload_line[hit_way_id];
    assign rdata     = base_line[{req.word_sel, 5'b00000} +: $bits(word_t)];

    always_comb begin
        for (int b = 0; b < $bits(line_strb_t); b++) begin
            merged_line[b*8 +: 8] = req.line_wstrb[b] ? req.line_wdata[b*8 +: 8]
                                                      : base_line[b*8 +: 8];
        end
    end

    assign line_we   = (hit && req.op == OP_WRITE) || fill.fill_done;
    assign write_way = fill.refill ? victim_way : hit_way_id;

    always_ff @(posedge clk) begin
        if (line_we) begin
            tag_mem[write_way][req.index]  <= req.tag;
            data_mem[write_way][req.index] <= merged_line;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (line_we) begin
            valid_bits[write_way][req.index] <= 1'b1;
            dirty_bits[write_way][req.index] <= (req.op == OP_WRITE);
        end
    end

    assign fill.victim_tag   = preload_tag[victim_way];
    assign fill.victim_line  = preload_line[victim_way];
    assign fill.victim_dirty = valid_bits[victim_way][req.index]
                            && dirty_bits[victim_way][req.index];

endmodule

// ==== hdl/cache_controller.sv ====
`timescale 1ns/1ps

module cache_controller import cache_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       valid,
    cache_req_if.sink  req,
    cache_fill_if.ctrl fill,
    input  logic       hit,
    input  logic       wr_rdy,
    output logic       accept,
    output logic       lookup_active,
    output way_t       victim_way,
    output logic       data_ok
);
    cache_state_t state;
    cache_state_t state_next;
    way_t         victim_ptr;
    logic         read_hit;

    assign read_hit = (state == ST_LOOKUP) && hit && (req.op == OP_READ);
    // combinational from valid and state, doubles as addr_ok
    assign accept   = valid && ((state == ST_IDLE) || read_hit);

    // writes answer in lookup whether they hit or not
    assign data_ok = ((state == ST_LOOKUP) && (hit || req.op == OP_WRITE))
                  || (fill.fill_done && req.op == OP_READ);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    state_next = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (!hit) begin
                    state_next = ST_MISS;
                end else if (!accept) begin
                    state_next = ST_IDLE;
                end
            end
            ST_MISS: begin
                // a dirty victim waits for the write channel
                if (!fill.victim_dirty) begin
                    state_next = ST_REFILL;
                end else if (wr_rdy) begin
                    state_next = ST_REPLACE;
                end
            end
            ST_REPLACE: state_next = ST_REFILL;
            ST_REFILL: begin
                if (fill.fill_done) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= ST_IDLE;
            victim_ptr <= '0;
        end else begin
            state <= state_next;
            if (fill.fill_done) begin
                victim_ptr <= victim_ptr + 1'b1;
            end
        end
    end

    assign fill.idle     = (state == ST_IDLE);
    assign fill.replace  = (state == ST_REPLACE);
    assign fill.refill   = (state == ST_REFILL);
    assign lookup_active = (state == ST_LOOKUP);
    assign victim_way    = victim_ptr;

endmodule

// ==== hdl/cache_mem_port.sv ====
`timescale 1ns/1ps

module cache_mem_port import cache_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    cache_req_if.sink  req,
    cache_fill_if.mem  fill,
    output logic       rd_req,
    output logic [2:0] rd_type,
    output addr_t      rd_addr,
    input  logic       rd_rdy,
    input  logic       ret_valid,
    input  logic       ret_last,
    input  word_t      ret_data,
    output logic       wr_req,
    output logic [2:0] wr_type,
    output addr_t      wr_addr,
    output logic [3:0] wr_wstrb,
    output line_t      wr_data
);
    logic      addr_sent;
    logic      beat_valid;
    word_sel_t beat_cnt;
    word_t     fill_words [LINE_BEATS];

    // read address handshake done once per refill
    always_ff @(posedge clk) begin
        if (!resetn || !fill.refill) begin
            addr_sent <= 1'b0;
        end else if (rd_rdy) begin
            addr_sent <= 1'b1;
        end
    end

    assign rd_req  = fill.refill && !addr_sent;
    assign rd_type = MEM_TYPE_LINE;
    assign rd_addr = {req.tag, req.index, offset_t'(0)};

    assign beat_valid = fill.refill && ret_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_cnt <= '0;
        end else if (beat_valid) begin
            beat_cnt <= ret_last ? '0 : beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid) begin
            fill_words[beat_cnt] <= ret_data;
        end
    end

    // last word goes straight into the line so it can be written on fill_done
    always_comb begin
        for (int i = 0; i < LINE_BEATS; i++) begin
            fill.fill_line[i*$bits(word_t) +: $bits(word_t)] =
                (beat_valid && beat_cnt == word_sel_t'(i)) ? ret_data : fill_words[i];
        end
    end

    assign fill.fill_done = beat_valid && ret_last;

    assign wr_req   = fill.replace;
    assign wr_type  = MEM_TYPE_LINE;
    assign wr_addr  = {fill.victim_tag, req.index, offset_t'(0)};
    assign wr_wstrb = 4'b1111;
    assign wr_data  = fill.victim_line;

endmodule

// ==== hdl/cache_top.sv ====
`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    // processor side
    input  logic       valid,
    input  logic       op,
    input  tag_t       tag,
    input  index_t     index,
    input  offset_t    offset,
    input  logic [3:0] wstrb,
    input  word_t      wdata,
    output logic       addr_ok,
    output logic       data_ok,
    output word_t      rdata,
    // memory read channel
    output logic       rd_req,
    output logic [2:0] rd_type,
    output addr_t      rd_addr,
    input  logic       rd_rdy,
    input  logic       ret_valid,
    input  logic       ret_last,
    input  word_t      ret_data,
    // memory write channel
    output logic       wr_req,
    output logic [2:0] wr_type,
    output addr_t      wr_addr,
    output logic [3:0] wr_wstrb,
    output line_t      wr_data,
    input  logic       wr_rdy
);
    logic hit;
    logic lookup_active;
    way_t victim_way;

    cache_req_if  req_bus ();
    cache_fill_if fill_bus ();

    cache_request_stage i_request_stage (
        .clk, .resetn, .valid, .op, .tag, .index, .offset, .wstrb, .wdata,
        .accept (addr_ok),
        .req    (req_bus.source)
    );

    cache_arrays i_arrays (
        .clk, .resetn, .valid, .index,
        .req  (req_bus.sink),
        .fill (fill_bus.arrays),
        .lookup_active, .victim_way, .hit, .rdata
    );

    cache_controller i_controller (
        .clk, .resetn, .valid,
        .req    (req_bus.sink),
        .fill   (fill_bus.ctrl),
        .hit, .wr_rdy,
        .accept (addr_ok),
        .lookup_active, .victim_way, .data_ok
    );

    cache_mem_port i_mem_port (
        .clk, .resetn,
        .req  (req_bus.sink),
        .fill (fill_bus.mem),
        .rd_req, .rd_type, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_type, .wr_addr, .wr_wstrb, .wr_data
    );

endmodule

// ==== test/cache_mem_model.sv ====
`timescale 1ns/1ps

// memory with random ready and return gaps
module cache_mem_model import cache_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       rd_req,
    input  addr_t      rd_addr,
    output logic       rd_rdy,
    output logic       ret_valid,
    output logic       ret_last,
    output word_t      ret_data,
    input  logic       wr_req,
    input  addr_t      wr_addr,
    input  line_t      wr_data,
    output logic       wr_rdy
);
    word_t       mem [logic [29:0]];
    logic [31:0] lfsr;

    // taps 32 22 2 1
    function automatic logic next_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    function automatic word_t read_word(addr_t a);
        if (mem.exists(a[31:2])) begin
            return mem[a[31:2]];
        end
        return {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    initial begin
        logic      take_rd;
        logic      take_ret;
        logic      take_wr;
        logic      pending;
        logic [2:0] beat;
        addr_t     base;
        addr_t     s_rd_addr;
        addr_t     s_wr_addr;
        line_t     s_wr_data;
        rd_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_last = 1'b0;
        ret_data = '0;
        wr_rdy = 1'b0;
        lfsr = 32'hcc4d;
        pending = 1'b0;
        beat = '0;
        base = '0;
        forever begin
            @(negedge clk);
            take_rd = rd_req && rd_rdy && !pending;
            take_ret = ret_valid;
            take_wr = wr_req;
            s_rd_addr = rd_addr;
            s_wr_addr = wr_addr;
            s_wr_data = wr_data;
            @(posedge clk);
            #2;
            if (!resetn) begin
                pending = 1'b0;
                beat = '0;
            end else begin
                if (take_wr) begin
                    for (int i = 0; i < LINE_BEATS; i++) begin
                        mem[s_wr_addr[31:2] + 30'(i)] = s_wr_data[i*32 +: 32];
                    end
                end
                if (take_ret) begin
                    pending = (beat != 3'd7);
                    beat = beat + 3'd1;
                end
                if (take_rd) begin
                    pending = 1'b1;
                    base = s_rd_addr;
                    beat = '0;
                end
            end
            rd_rdy = next_bit();
            wr_rdy = next_bit();
            ret_valid = pending && next_bit();
            ret_last = ret_valid && (beat == 3'd7);
            ret_data = ret_valid ? read_word(base + {27'd0, beat, 2'd0}) : '0;
        end
    end

endmodule

// ==== test/cache_assertions.sv ====
`timescale 1ns/1ps

module cache_assertions import cache_pkg::*; (
    input logic  clk,
    input logic  resetn,
    input logic  valid,
    input logic  addr_ok,
    input logic  data_ok,
    input logic  rd_req,
    input logic  rd_rdy,
    input addr_t rd_addr,
    input logic  wr_req
);
    // requests accepted but not yet answered
    int outstanding;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(valid && addr_ok) - int'(data_ok);
        end
    end

    a_wr_single: assert property (@(posedge clk) disable iff (!resetn) wr_req |=> !wr_req)
        else $error("wr_req held for two cycles");

    a_rd_hold: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> $stable(rd_addr))
        else $error("rd_addr changed while waiting for rd_rdy");

    a_ok_after_req: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> outstanding > 0)
        else $error("data_ok without an accepted request");

endmodule

bind cache_top cache_assertions i_assertions (.*);

// ==== test/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

    typedef struct packed {
        logic [3:0] test;
        logic       op;
        addr_t      addr;
        logic [3:0] strb;
        word_t      data;
    } row_t;

    localparam int NUM_ROWS    = 12;
    localparam int CYCLE_LIMIT = NUM_ROWS * 80 + 100;

    logic       clk;
    logic       resetn;
    logic       valid;
    logic       op;
    tag_t       tag;
    index_t     index;
    offset_t    offset;
    logic [3:0] wstrb;
    word_t      wdata;
    logic       addr_ok;
    logic       data_ok;
    word_t      rdata;
    logic       rd_req;
    logic [2:0] rd_type;
    addr_t      rd_addr;
    logic       rd_rdy;
    logic       ret_valid;
    logic       ret_last;
    word_t      ret_data;
    logic       wr_req;
    logic [2:0] wr_type;
    addr_t      wr_addr;
    logic [3:0] wr_wstrb;
    line_t      wr_data;
    logic       wr_rdy;

    row_t       rows [NUM_ROWS];
    logic [7:0] ref_mem [addr_t];
    tag_t       m_tag [2][128];
    logic       m_valid [2][128];
    logic       m_dirty [2][128];
    logic       m_ptr;
    logic       resp_op_q [$];
    word_t      resp_data_q [$];
    addr_t      rd_addr_q [$];
    addr_t      wb_addr_q [$];
    line_t      wb_line_q [$];
    logic       lookup_ok_due;
    logic       lookup_read_hit;
    int errors;
    int checks;
    int tests;
    int cycles;
    int rd_seen;
    int wr_seen;

    cache_top i_dut (.*);

    cache_mem_model i_mem (
        .clk, .resetn, .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic report_mismatch(string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic report_error(string msg);
        $display("error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    function automatic logic [7:0] ref_byte(addr_t a);
        word_t w;
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        w = {a[15:0] & 16'hfffc, a[31:16]} ^ 32'h3c5a_96e1;
        return w[{a[1:0], 3'b000} +: 8];
    endfunction

    function automatic line_t ref_line(addr_t base);
        line_t l;
        for (int b = 0; b < 32; b++) begin
            l[b*8 +: 8] = ref_byte(base + addr_t'(b));
        end
        return l;
    endfunction

    // predicted hit or miss, victim and response, in request order
    task automatic predict_access(row_t row);
        index_t idx;
        tag_t   tg;
        addr_t  waddr;
        int     way;
        logic   hit;
        idx = row.addr[11:5];
        tg = row.addr[31:12];
        waddr = {row.addr[31:2], 2'b00};
        way = -1;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == tg) begin
                way = w;
            end
        end
        hit = (way >= 0);
        if (way < 0) begin
            way = int'(m_ptr);
            if (m_valid[way][idx] && m_dirty[way][idx]) begin
                wb_addr_q.push_back({m_tag[way][idx], idx, 5'b00000});
                wb_line_q.push_back(ref_line({m_tag[way][idx], idx, 5'b00000}));
            end
            rd_addr_q.push_back({tg, idx, 5'b00000});
            m_tag[way][idx] = tg;
            m_valid[way][idx] = 1'b1;
            m_dirty[way][idx] = 1'b0;
            m_ptr = ~m_ptr;
        end
        if (row.op == OP_WRITE) begin
            for (int b = 0; b < 4; b++) begin
                if (row.strb[b]) begin
                    ref_mem[waddr + addr_t'(b)] = row.data[b*8 +: 8];
                end
            end
            m_dirty[way][idx] = 1'b1;
        end
        resp_op_q.push_back(row.op);
        resp_data_q.push_back({ref_byte(waddr + 3), ref_byte(waddr + 2),
                               ref_byte(waddr + 1), ref_byte(waddr)});
        // hits and writes answer in the lookup cycle
        lookup_ok_due = hit || (row.op == OP_WRITE);
        lookup_read_hit = hit && (row.op == OP_READ);
    endtask

    // hold the request until addr_ok is seen at an edge
    task automatic send_row(row_t row);
        logic taken;
        valid = 1'b1;
        op = row.op;
        {tag, index, offset} = row.addr;
        wstrb = row.strb;
        wdata = row.data;
        do begin
            @(negedge clk);
            taken = addr_ok;
            @(posedge clk);
            #2;
        end while (!taken);
        predict_access(row);
        valid = 1'b0;
    endtask

    task automatic finish_test(int t, int err_start);
        while (resp_op_q.size() > 0 || rd_addr_q.size() > 0 || wb_addr_q.size() > 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        tests++;
        $display("test %0d: %0d read bursts, %0d writebacks, %s", t, rd_seen, wr_seen,
                 (errors == err_start) ? "ok" : "errors");
        rd_seen = 0;
        wr_seen = 0;
        @(posedge clk);
        #2;
    endtask

    always @(negedge clk) begin : response_monitor
        logic  exp_op;
        word_t exp_data;
        if (resetn && lookup_ok_due) begin
            checks++;
            lookup_ok_due = 1'b0;
            if (!data_ok) begin
                report_mismatch("data_ok low in the cycle after the request was taken");
            end
            // only a read hit lets the next request in during lookup
            if (addr_ok !== (valid && lookup_read_hit)) begin
                report_mismatch($sformatf("addr_ok %b in lookup, expected %b", addr_ok,
                                          valid && lookup_read_hit));
            end
        end
        if (resetn && data_ok) begin
            checks++;
            if (resp_op_q.size() == 0) begin
                report_error("data_ok with no request waiting for it");
            end else begin
                exp_op = resp_op_q.pop_front();
                exp_data = resp_data_q.pop_front();
                if (exp_op == OP_READ && rdata !== exp_data) begin
                    report_mismatch($sformatf("rdata %h, expected %h", rdata, exp_data));
                end
            end
        end
    end

    always @(negedge clk) begin : memory_monitor
        addr_t exp_addr;
        line_t exp_line;
        if (resetn && rd_req && rd_rdy) begin
            checks++;
            rd_seen++;
            if (rd_addr_q.size() == 0) begin
                report_error("read burst requested on what should be a hit");
            end else begin
                exp_addr = rd_addr_q.pop_front();
                if (rd_type !== MEM_TYPE_LINE || rd_addr !== exp_addr) begin
                    report_mismatch($sformatf("rd type %0d addr %h, expected addr %h",
                                              rd_type, rd_addr, exp_addr));
                end
            end
        end
        if (resetn && wr_req) begin
            checks++;
            wr_seen++;
            if (wb_addr_q.size() == 0) begin
                report_error("writeback issued with no dirty victim");
            end else begin
                exp_addr = wb_addr_q.pop_front();
                exp_line = wb_line_q.pop_front();
                if (wr_type !== MEM_TYPE_LINE || wr_wstrb !== 4'b1111
                        || wr_addr !== exp_addr || wr_data !== exp_line) begin
                    report_mismatch($sformatf(
                        "writeback addr %h strobe %b, expected %h, or line differs",
                        wr_addr, wr_wstrb, exp_addr));
                end
            end
        end
    end

    initial begin
        int err_start;
        resetn = 1'b0;
        valid = 1'b0;
        op = OP_READ;
        {tag, index, offset} = '0;
        wstrb = '0;
        wdata = '0;
        m_ptr = 1'b0;
        lookup_ok_due = 1'b0;
        lookup_read_hit = 1'b0;
        for (int s = 0; s < 128; s++) begin
            for (int w = 0; w < 2; w++) begin
                m_valid[w][s] = 1'b0;
                m_dirty[w][s] = 1'b0;
            end
        end
        // test, op, address, strobe, data
        rows[0]  = '{4'd2, OP_READ,  32'h0000_1024, 4'h0, 32'h0};
        rows[1]  = '{4'd3, OP_READ,  32'h0000_1028, 4'h0, 32'h0};
        rows[2]  = '{4'd3, OP_READ,  32'h0000_103c, 4'h0, 32'h0};
        rows[3]  = '{4'd3, OP_READ,  32'h0000_1020, 4'h0, 32'h0};
        rows[4]  = '{4'd4, OP_WRITE, 32'h0000_1024, 4'b0110, 32'haabb_ccdd};
        rows[5]  = '{4'd4, OP_READ,  32'h0000_1024, 4'h0, 32'h0};
        rows[6]  = '{4'd5, OP_WRITE, 32'h0000_2048, 4'b1001, 32'h1122_3344};
        rows[7]  = '{4'd5, OP_READ,  32'h0000_2048, 4'h0, 32'h0};
        // three tags on set 3 push out a dirty line twice
        rows[8]  = '{4'd6, OP_WRITE, 32'h0001_0060, 4'hf, 32'hdead_0001};
        rows[9]  = '{4'd6, OP_WRITE, 32'h0002_0064, 4'hf, 32'hdead_0002};
        rows[10] = '{4'd6, OP_READ,  32'h0003_0068, 4'h0, 32'h0};
        rows[11] = '{4'd6, OP_READ,  32'h0001_0060, 4'h0, 32'h0};
        repeat (2) @(posedge clk);
        #2;
        resetn = 1'b1;
        err_start = errors;
        repeat (4) begin
            @(negedge clk);
            checks++;
            if (data_ok || rd_req || wr_req) begin
                report_mismatch("data_ok, rd_req or wr_req high with no request");
            end
        end
        finish_test(1, err_start);
        err_start = errors;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (r > 0 && rows[r].test != rows[r-1].test) begin
                finish_test(int'(rows[r-1].test), err_start);
                err_start = errors;
            end
            send_row(rows[r]);
        end
        finish_test(int'(rows[NUM_ROWS-1].test), err_start);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hdl/cache_pkg.sv
hdl/cache_req_if.sv
hdl/cache_fill_if.sv
hdl/cache_request_stage.sv
hdl/cache_arrays.sv
hdl/cache_controller.sv
hdl/cache_mem_port.sv
hdl/cache_top.sv
test/cache_mem_model.sv
test/cache_assertions.sv
test/cache_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := cache_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
